// ==== include/cp0_cfg.svh ====
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

`define TLB_NUM            16
`define TLB_IDX_W          $clog2(`TLB_NUM)

`define STATUS_INIT        32'h0040_0000  // BEV set
`define CAUSE_INIT         32'h0000_0000
`define PRID_INIT          32'h0001_8000
`define CONFIG_INIT        32'h8000_0003
// MMU size field of Config1 sits at 30:25
`define CONFIG1_INIT       (32'(`TLB_NUM - 1) << 25)
`define EBASE_INIT         32'h8000_0000

`define IE_BIT             0
`define EXL_BIT            1
`define BEV_BIT            22
`define IM_BITS            15:8
`define IP_SW_BITS         9:8
`define IP_HW_BITS         15:10
`define IP7_BIT            15
`define BD_BIT             31
`define EXC_CODE_BITS      6:2
`define VPN2_BITS          31:13
`define ASID_BITS          7:0
`define PFN_BITS           25:6
`define FLAG_BITS          5:0
`define MASK_BITS          24:13
`define BAD_VPN2_BITS      22:4
`define PTE_BASE_BITS      31:23

// bits that mtc0 may change
`define INDEX_WMASK        (32'(`TLB_NUM) - 32'd1)
`define WIRED_WMASK        (32'(`TLB_NUM) - 32'd1)
`define ENTRY_LO_WMASK     32'h03FF_FFFF
`define CONTEXT_WMASK      32'hFF80_0000
`define PAGE_MASK_WMASK    32'h01FF_E000
`define ENTRY_HI_WMASK     32'hFFFF_E0FF
`define STATUS_WMASK       32'h0040_FF03
`define CAUSE_WMASK        32'h0000_0300
`define EBASE_WMASK        32'hFFFF_F000
`define CONFIG_WMASK       32'h7E00_0007

`endif

// ==== rtl/cp0_pkg.sv ====
package cp0_pkg;

   typedef enum logic [4:0] {
      INDEX     = 5'd0,
      RANDOM    = 5'd1,
      ENTRY_LO0 = 5'd2,
      ENTRY_LO1 = 5'd3,
      CONTEXT   = 5'd4,
      PAGE_MASK = 5'd5,
      WIRED     = 5'd6,
      BADVADDR  = 5'd8,
      COUNT     = 5'd9,
      ENTRY_HI  = 5'd10,
      COMPARE   = 5'd11,
      STATUS    = 5'd12,
      CAUSE     = 5'd13,
      EPC       = 5'd14,
      PRID      = 5'd15,  // sel 1 is EBase
      CONFIG    = 5'd16   // sel 1 is Config1
   } cp0_reg_e;

   typedef enum logic [4:0] {
      INT  = 5'd0,
      MOD  = 5'd1,
      TLBL = 5'd2,
      TLBS = 5'd3,
      ADEL = 5'd4,
      ADES = 5'd5,
      SYS  = 5'd8,
      BP   = 5'd9,
      RI   = 5'd10,
      OV   = 5'd12,
      ERET = 5'd31
   } exc_code_e;

   typedef enum logic [2:0] {
      NONE  = 3'd0,
      TLBP  = 3'd1,
      TLBR  = 3'd2,
      TLBWI = 3'd3,
      TLBWR = 3'd4
   } tlb_op_e;

endpackage

// ==== rtl/tlb_entry.sv ====
`include "cp0_cfg.svh"

module tlb_entry (
   input  logic        clk,
   input  logic        rst,
   input  logic        we,
   input  logic [31:0] w_hi,
   input  logic [31:0] w_lo0,
   input  logic [31:0] w_lo1,
   input  logic [31:0] w_mask,
   input  logic [31:0] key_hi,
   output logic        hit,
   output logic [31:0] hi,
   output logic [31:0] lo0,
   output logic [31:0] lo1,
   output logic [31:0] mask
);

   logic        vld;  // written at least once since reset
   logic [18:0] vpn2;
   logic [7:0]  asid;
   logic        g;
   logic [11:0] mask_q;
   logic [25:1] lo0_q, lo1_q;  // PFN and C/D/V, G kept apart
   logic [18:0] vpn2_diff;

   always_ff @(posedge clk) begin
      if (rst) begin
         vld    <= 1'b0;
         vpn2   <= '0;
         asid   <= '0;
         g      <= 1'b0;
         mask_q <= '0;
         lo0_q  <= '0;
         lo1_q  <= '0;
      end else if (we) begin
         vld    <= 1'b1;
         vpn2   <= w_hi[`VPN2_BITS];
         asid   <= w_hi[`ASID_BITS];
         g      <= w_lo0[0] & w_lo1[0];  // global only if both halves say so
         mask_q <= w_mask[`MASK_BITS];
         lo0_q  <= w_lo0[25:1];
         lo1_q  <= w_lo1[25:1];
      end
   end

   assign vpn2_diff = (vpn2 ^ key_hi[`VPN2_BITS]) & ~{7'b0, mask_q};
   assign hit = vld && vpn2_diff == '0 && (g || asid == key_hi[`ASID_BITS]);

   assign hi   = {vpn2, 5'b0, asid};
   assign lo0  = {6'b0, lo0_q, g};
   assign lo1  = {6'b0, lo1_q, g};
   assign mask = {7'b0, mask_q, 13'b0};

endmodule

// ==== rtl/tlb_write_ctrl.sv ====
`include "cp0_cfg.svh"

module tlb_write_ctrl (
   input  cp0_pkg::tlb_op_e      tlb_op,
   input  logic                  flush_exception,
   input  logic [`TLB_IDX_W-1:0] index,
   input  logic [`TLB_IDX_W-1:0] random,
   output logic [`TLB_NUM-1:0]   we
);
   import cp0_pkg::*;

   logic [`TLB_IDX_W-1:0] slot;
   logic                  do_write;

   assign slot     = (tlb_op == TLBWR) ? random : index;  // tlbwi uses Index
   assign do_write = !flush_exception && tlb_op inside {TLBWI, TLBWR};

   always_comb begin
      we = '0;
      if (do_write) we[slot] = 1'b1;
   end

endmodule

// ==== rtl/tlb_probe_read.sv ====
`include "cp0_cfg.svh"

module tlb_probe_read (
   input  logic                  clk,
   input  logic                  rst,
   input  cp0_pkg::tlb_op_e      tlb_op,
   input  logic [`TLB_NUM-1:0]   hit,
   input  logic [31:0]           hi [`TLB_NUM],
   input  logic [31:0]           lo0 [`TLB_NUM],
   input  logic [31:0]           lo1 [`TLB_NUM],
   input  logic [31:0]           mask [`TLB_NUM],
   input  logic [`TLB_IDX_W-1:0] index,
   output logic [`TLB_IDX_W-1:0] probe_index,
   output logic                  probe_miss,
   output logic [31:0]           rd_hi,
   output logic [31:0]           rd_lo0,
   output logic [31:0]           rd_lo1,
   output logic [31:0]           rd_mask
);
   import cp0_pkg::*;

   // walk down so the lowest hit wins
   always_comb begin
      probe_index = '0;
      for (int i = `TLB_NUM - 1; i >= 0; i--) begin
         if (hit[i]) probe_index = `TLB_IDX_W'(i);
      end
   end

   assign probe_miss = ~|hit;

   assign rd_hi   = hi[index];
   assign rd_lo0  = lo0[index];
   assign rd_lo1  = lo1[index];
   assign rd_mask = mask[index];

   assert property (@(posedge clk) disable iff (rst) tlb_op == TLBP |-> $onehot0(hit))
      else $error("tlbp matched several entries: %b", hit);

endmodule

// ==== rtl/cp0_regs.sv ====
`include "cp0_cfg.svh"

module cp0_regs (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [5:0]            ext_int,
   input  logic                  stall,
   input  cp0_pkg::cp0_reg_e     addr,
   input  logic [2:0]            sel,
   input  logic                  wen,
   input  logic [31:0]           wdata,
   input  logic                  flush_exception,
   input  cp0_pkg::exc_code_e    except_type,
   input  logic [31:0]           pc,
   input  logic                  in_delayslot,
   input  logic [31:0]           badvaddr,
   input  cp0_pkg::tlb_op_e      tlb_op,
   input  logic [`TLB_IDX_W-1:0] probe_index,
   input  logic                  probe_miss,
   input  logic [31:0]           rd_hi,
   input  logic [31:0]           rd_lo0,
   input  logic [31:0]           rd_lo1,
   input  logic [31:0]           rd_mask,
   output logic [31:0]           rdata,
   output logic [31:0]           status,
   output logic [31:0]           cause,
   output logic [31:0]           epc,
   output logic [31:0]           ebase,
   output logic [31:0]           entry_hi,
   output logic [31:0]           entry_lo0,
   output logic [31:0]           entry_lo1,
   output logic [31:0]           page_mask,
   output logic [`TLB_IDX_W-1:0] index,
   output logic [`TLB_IDX_W-1:0] random
);
   import cp0_pkg::*;

   logic                  index_p;  // probe failure
   logic [`TLB_IDX_W-1:0] wired;
   logic [31:0]           context_q, badvaddr_q, count_q, compare_q, cause_q;
   logic [31:0]           config_q;
   logic                  tick, timer_int;
   logic                  exc, eret, tlb_exc, addr_exc, do_tlbp, do_tlbr;
   logic                  wr_hi, wr_context;
   logic [18:0]           vpn2_keep;
   logic [19:0]           pfn_keep;

   function automatic logic [31:0] merge(input logic [31:0] cur, nxt, msk);
      return (cur & ~msk) | (nxt & msk);
   endfunction

   assign eret     = flush_exception && except_type == ERET;
   assign exc      = flush_exception && except_type != ERET;
   assign tlb_exc  = exc && except_type inside {MOD, TLBL, TLBS};
   assign addr_exc = tlb_exc || (exc && except_type inside {ADEL, ADES});
   assign do_tlbp  = !flush_exception && tlb_op == TLBP;
   assign do_tlbr  = !flush_exception && tlb_op == TLBR;
   assign wr_hi      = wen && addr == ENTRY_HI;
   assign wr_context = wen && addr == CONTEXT;

   // larger pages drop the low VPN2 / PFN bits
   assign vpn2_keep = ~{7'b0, rd_mask[`MASK_BITS]};
   assign pfn_keep  = ~{7'b0, rd_mask[`MASK_BITS], 1'b0};

   always_ff @(posedge clk) begin
      if (rst) begin
         status    <= `STATUS_INIT;
         cause_q   <= `CAUSE_INIT;
         ebase     <= `EBASE_INIT;
         config_q  <= `CONFIG_INIT;
         wired     <= '0;
         compare_q <= '0;
         count_q   <= '0;
         tick      <= 1'b0;
         timer_int <= 1'b0;
      end else begin
         tick <= ~tick;
         if (wen && addr == COUNT) count_q <= wdata;
         else if (tick)            count_q <= count_q + 32'd1;
         if (wen && addr == COMPARE) begin
            compare_q <= wdata;
            timer_int <= 1'b0;
         end else if (compare_q != '0 && count_q == compare_q) begin
            timer_int <= 1'b1;
         end
         if (wen && addr == WIRED)           wired <= wdata[`TLB_IDX_W-1:0];
         if (wen && addr == PRID && sel == 3'd1)   ebase <= merge(ebase, wdata, `EBASE_WMASK);
         if (wen && addr == CONFIG && sel == 3'd0) config_q <= merge(config_q, wdata, `CONFIG_WMASK);
         if (eret)                      status[`EXL_BIT] <= 1'b0;
         else if (exc)                  status[`EXL_BIT] <= 1'b1;
         else if (wen && addr == STATUS) status <= merge(status, wdata, `STATUS_WMASK);
         if (exc) begin
            cause_q[`BD_BIT]        <= in_delayslot;
            cause_q[`EXC_CODE_BITS] <= except_type;
         end else if (wen && addr == CAUSE) begin
            cause_q <= merge(cause_q, wdata, `CAUSE_WMASK);
         end else begin
            cause_q[`IP_HW_BITS] <= stall ? 6'b0 : ext_int;
         end
      end
   end

   // random walks down from the top entry to wired, then wraps
   always_ff @(posedge clk) begin
      if (rst || (wen && addr == WIRED) || random == wired) random <= `TLB_IDX_W'(`TLB_NUM - 1);
      else                                                  random <= random - 1'b1;
   end

   always_ff @(posedge clk) begin
      if (exc)                  epc <= in_delayslot ? pc - 32'd4 : pc;
      else if (wen && addr == EPC) epc <= wdata;
      if (addr_exc) badvaddr_q <= badvaddr;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         index_p   <= 1'b0;
         index     <= '0;
         entry_hi  <= '0;
         entry_lo0 <= '0;
         entry_lo1 <= '0;
         page_mask <= '0;
         context_q <= '0;
      end else begin
         if (do_tlbp) begin
            index_p <= probe_miss;
            index   <= probe_index;
         end else if (wen && addr == INDEX) begin
            index <= wdata[`TLB_IDX_W-1:0];
         end
         if (do_tlbr) begin
            entry_hi  <= {rd_hi[`VPN2_BITS] & vpn2_keep, 5'b0, rd_hi[`ASID_BITS]};
            entry_lo0 <= {6'b0, rd_lo0[`PFN_BITS] & pfn_keep, rd_lo0[`FLAG_BITS]};
            entry_lo1 <= {6'b0, rd_lo1[`PFN_BITS] & pfn_keep, rd_lo1[`FLAG_BITS]};
            page_mask <= rd_mask;
         end else begin
            if (wr_hi)        entry_hi <= merge(entry_hi, wdata, `ENTRY_HI_WMASK);
            else if (tlb_exc) entry_hi[`VPN2_BITS] <= badvaddr[`VPN2_BITS];
            if (wen && addr == ENTRY_LO0) entry_lo0 <= merge(entry_lo0, wdata, `ENTRY_LO_WMASK);
            if (wen && addr == ENTRY_LO1) entry_lo1 <= merge(entry_lo1, wdata, `ENTRY_LO_WMASK);
            if (wen && addr == PAGE_MASK) page_mask <= merge(page_mask, wdata, `PAGE_MASK_WMASK);
         end
         if (tlb_exc)         context_q[`BAD_VPN2_BITS] <= badvaddr[`VPN2_BITS];
         else if (wr_context) context_q <= merge(context_q, wdata, `CONTEXT_WMASK);
      end
   end

   always_comb begin
      cause = cause_q;
      cause[`IP7_BIT] = cause_q[`IP7_BIT] | timer_int;  // timer shares IP7 with ext_int[5]
   end

   always_comb begin
      case (addr)
         INDEX:     rdata = {index_p, {(31 - `TLB_IDX_W){1'b0}}, index};
         RANDOM:    rdata = {{(32 - `TLB_IDX_W){1'b0}}, random};
         ENTRY_LO0: rdata = entry_lo0;
         ENTRY_LO1: rdata = entry_lo1;
         CONTEXT:   rdata = context_q;
         PAGE_MASK: rdata = page_mask;
         WIRED:     rdata = {{(32 - `TLB_IDX_W){1'b0}}, wired};
         BADVADDR:  rdata = badvaddr_q;
         COUNT:     rdata = count_q;
         ENTRY_HI:  rdata = entry_hi;
         COMPARE:   rdata = compare_q;
         STATUS:    rdata = status;
         CAUSE:     rdata = cause;
         EPC:       rdata = epc;
         PRID:      rdata = (sel == 3'd0) ? `PRID_INIT : ebase;
         CONFIG:    rdata = (sel == 3'd0) ? config_q : `CONFIG1_INIT;
         default:   rdata = '0;
      endcase
   end

   assert property (@(posedge clk) disable iff (rst)
      random >= wired && 32'(random) <= `TLB_NUM - 1)
      else $error("random %0d outside wired %0d", random, wired);

   // tlbr/tlbp and mtc0 sit in the same pipe stage
   assert property (@(posedge clk) disable iff (rst) wen |-> !(tlb_op inside {TLBR, TLBP}))
      else $error("tlb op %s with mtc0", tlb_op.name());

endmodule

// ==== rtl/mmu_cp0_top.sv ====
`include "cp0_cfg.svh"

module mmu_cp0_top (
   input  logic               clk,
   input  logic               rst,
   input  logic [5:0]         ext_int,
   input  logic               stall,
   input  cp0_pkg::cp0_reg_e  addr,
   input  logic [2:0]         sel,
   input  logic               wen,
   input  logic [31:0]        wdata,
   input  logic               flush_exception,
   input  cp0_pkg::exc_code_e except_type,
   input  logic [31:0]        pc,
   input  logic               in_delayslot,
   input  logic [31:0]        badvaddr,
   input  cp0_pkg::tlb_op_e   tlb_op,
   output logic [31:0]        rdata,
   output logic [31:0]        status,
   output logic [31:0]        cause,
   output logic [31:0]        epc,
   output logic [31:0]        ebase
);

   logic [31:0]           entry_hi, entry_lo0, entry_lo1, page_mask;
   logic [`TLB_IDX_W-1:0] index, random, probe_index;
   logic                  probe_miss;
   logic [31:0]           rd_hi, rd_lo0, rd_lo1, rd_mask;
   logic [`TLB_NUM-1:0]   we, hit;
   logic [31:0]           e_hi [`TLB_NUM];
   logic [31:0]           e_lo0 [`TLB_NUM];
   logic [31:0]           e_lo1 [`TLB_NUM];
   logic [31:0]           e_mask [`TLB_NUM];

   cp0_regs cp0_regs_inst (
      .clk, .rst, .ext_int, .stall, .addr, .sel, .wen, .wdata,
      .flush_exception, .except_type, .pc, .in_delayslot, .badvaddr, .tlb_op,
      .probe_index, .probe_miss, .rd_hi, .rd_lo0, .rd_lo1, .rd_mask,
      .rdata, .status, .cause, .epc, .ebase,
      .entry_hi, .entry_lo0, .entry_lo1, .page_mask, .index, .random
   );

   tlb_write_ctrl tlb_write_ctrl_inst (
      .tlb_op, .flush_exception, .index, .random, .we
   );

   for (genvar i = 0; i < `TLB_NUM; i++) begin : g_entry
      tlb_entry tlb_entry_inst (
         .clk, .rst, .we(we[i]),
         .w_hi(entry_hi), .w_lo0(entry_lo0), .w_lo1(entry_lo1), .w_mask(page_mask),
         .key_hi(entry_hi),  // tlbp searches with EntryHi
         .hit(hit[i]), .hi(e_hi[i]), .lo0(e_lo0[i]), .lo1(e_lo1[i]), .mask(e_mask[i])
      );
   end

   tlb_probe_read tlb_probe_read_inst (
      .clk, .rst, .tlb_op, .hit,
      .hi(e_hi), .lo0(e_lo0), .lo1(e_lo1), .mask(e_mask), .index,
      .probe_index, .probe_miss, .rd_hi, .rd_lo0, .rd_lo1, .rd_mask
   );

endmodule

// ==== dv/mmu_cp0_tb.sv ====
`include "cp0_cfg.svh"

module mmu_cp0_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import cp0_pkg::*;

   localparam int PERIOD = 40;
   localparam int GROUPS = 6;

   logic        clk = 1'b0;
   logic        rst;
   logic [5:0]  ext_int;
   logic        stall;
   cp0_reg_e    addr;
   logic [2:0]  sel;
   logic        wen;
   logic [31:0] wdata;
   logic        flush_exception;
   exc_code_e   except_type;
   logic [31:0] pc;
   logic        in_delayslot;
   logic [31:0] badvaddr;
   tlb_op_e     tlb_op;
   logic [31:0] rdata, status, cause, epc, ebase;

   integer seed = 75488;
   int     errors = 0;

   // check requests, only ever changed on the falling edge
   logic        chk_rd, chk_rand, chk_exc, chk_eret, chk_count, timer_armed;
   logic [31:0] exp_rd, exp_msk, exp_epc, wired_ref, count_base;
   logic        exp_bd;
   logic [4:0]  exp_code;
   string       chk_name;
   int          count_gap, timer_wait;

   // shadow of what was written into each TLB entry
   logic [31:0] hi_ref [`TLB_NUM];
   logic [31:0] lo0_ref [`TLB_NUM];
   logic [31:0] lo1_ref [`TLB_NUM];
   logic [31:0] mask_ref [`TLB_NUM];

   mmu_cp0_top mmu_cp0_top_inst (
      .clk, .rst, .ext_int, .stall, .addr, .sel, .wen, .wdata,
      .flush_exception, .except_type, .pc, .in_delayslot, .badvaddr, .tlb_op,
      .rdata, .status, .cause, .epc, .ebase
   );

   always #(PERIOD / 2) clk = ~clk;

   assert property (@(posedge clk) disable iff (rst) chk_rd |-> (rdata & exp_msk) == exp_rd)
      else begin
         errors++;
         $display("Fail %0t rdata(%s): expected %h got %h", $time, chk_name, exp_rd,
                  $sampled(rdata) & exp_msk);
      end

   // EBase also leaves the block on its own port
   assert property (@(posedge clk) disable iff (rst)
      chk_rd && addr == PRID && sel == 3'd1 |-> (ebase & exp_msk) == exp_rd)
      else begin
         errors++;
         $display("Fail %0t ebase: expected %h got %h", $time, exp_rd,
                  $sampled(ebase) & exp_msk);
      end

   assert property (@(posedge clk) disable iff (rst)
      chk_rand |-> rdata >= wired_ref && rdata <= `TLB_NUM - 1)
      else begin
         errors++;
         $display("Fail %0t random: expected %0d..%0d got %0d", $time, wired_ref,
                  `TLB_NUM - 1, $sampled(rdata));
      end

   assert property (@(posedge clk) disable iff (rst) chk_exc |-> epc == exp_epc)
      else begin
         errors++;
         $display("Fail %0t epc: expected %h got %h", $time, exp_epc, $sampled(epc));
      end

   assert property (@(posedge clk) disable iff (rst) chk_exc |-> cause[`BD_BIT] == exp_bd)
      else begin
         errors++;
         $display("Fail %0t cause.bd: expected %b got %b", $time, exp_bd,
                  $sampled(cause[`BD_BIT]));
      end

   assert property (@(posedge clk) disable iff (rst)
      chk_exc |-> cause[`EXC_CODE_BITS] == exp_code)
      else begin
         errors++;
         $display("Fail %0t cause.exccode: expected %0d got %0d", $time, exp_code,
                  $sampled(cause[`EXC_CODE_BITS]));
      end

   assert property (@(posedge clk) disable iff (rst) chk_exc |-> status[`EXL_BIT])
      else begin
         errors++;
         $display("Fail %0t status.exl: expected 1 got 0", $time);
      end

   assert property (@(posedge clk) disable iff (rst) chk_eret |-> !status[`EXL_BIT])
      else begin
         errors++;
         $display("Fail %0t status.exl after eret: expected 0 got 1", $time);
      end

   // Count ticks every other cycle
   assert property (@(posedge clk) disable iff (rst)
      chk_count |-> rdata - count_base >= count_gap / 2 - 1 &&
                    rdata - count_base <= count_gap / 2 + 1)
      else begin
         errors++;
         $display("Fail %0t count delta over %0d cycles: expected %0d got %0d", $time,
                  count_gap, count_gap / 2, $sampled(rdata) - count_base);
      end

   assert property (@(posedge clk) disable iff (rst)
      timer_armed && !cause[`IP7_BIT] |-> timer_wait < 14)
      else begin
         errors++;
         $display("Timer interrupt did not reach Cause IP7 within 14 cycles at %0t", $time);
      end

   task automatic mtc0(input cp0_reg_e r, input logic [2:0] s, input logic [31:0] d);
      @(negedge clk);
      addr  = r;
      sel   = s;
      wen   = 1'b1;
      wdata = d;
      @(negedge clk);
      wen = 1'b0;
   endtask

   // starts and ends on a falling edge
   task automatic expect_read(input cp0_reg_e r, input logic [2:0] s, input logic [31:0] m,
                              input logic [31:0] d, input string name);
      addr     = r;
      sel      = s;
      exp_msk  = m;
      exp_rd   = d & m;
      chk_name = name;
      chk_rd   = 1'b1;
      @(negedge clk);
      chk_rd = 1'b0;
   endtask

   task automatic write_read(input cp0_reg_e r, input logic [2:0] s, input logic [31:0] m,
                             input string name);
      logic [31:0] d;
      d = $random(seed);
      mtc0(r, s, d);
      expect_read(r, s, m, d, name);
   endtask

   task automatic tlb_cmd(input tlb_op_e op);
      @(negedge clk);
      tlb_op = op;
      @(negedge clk);
      tlb_op = NONE;
   endtask

   task automatic take_exception(input exc_code_e code, input logic [31:0] at_pc,
                                 input logic ds, input logic [31:0] bad);
      @(negedge clk);
      flush_exception = 1'b1;
      except_type     = code;
      pc              = at_pc;
      in_delayslot    = ds;
      badvaddr        = bad;
      @(negedge clk);
      flush_exception = 1'b0;
      if (code == ERET) begin
         chk_eret = 1'b1;
      end else begin
         exp_epc  = ds ? at_pc - 32'd4 : at_pc;  // branch sits one word back
         exp_bd   = ds;
         exp_code = code;
         chk_exc  = 1'b1;
      end
      @(negedge clk);
      chk_exc  = 1'b0;
      chk_eret = 1'b0;
   endtask

   task automatic check_registers();
      write_read(INDEX, 3'd0, `INDEX_WMASK, "index");
      write_read(ENTRY_LO0, 3'd0, `ENTRY_LO_WMASK, "entry_lo0");
      write_read(ENTRY_LO1, 3'd0, `ENTRY_LO_WMASK, "entry_lo1");
      write_read(CONTEXT, 3'd0, `CONTEXT_WMASK, "context");
      write_read(PAGE_MASK, 3'd0, `PAGE_MASK_WMASK, "page_mask");
      write_read(WIRED, 3'd0, `WIRED_WMASK, "wired");
      write_read(COUNT, 3'd0, 32'hFFFF_FFFF, "count");
      write_read(ENTRY_HI, 3'd0, `ENTRY_HI_WMASK, "entry_hi");
      write_read(COMPARE, 3'd0, 32'hFFFF_FFFF, "compare");
      write_read(STATUS, 3'd0, `STATUS_WMASK, "status");
      write_read(CAUSE, 3'd0, `CAUSE_WMASK, "cause");
      write_read(EPC, 3'd0, 32'hFFFF_FFFF, "epc");
      write_read(PRID, 3'd1, `EBASE_WMASK, "ebase");
      write_read(CONFIG, 3'd0, `CONFIG_WMASK, "config");
      expect_read(PRID, 3'd0, 32'hFFFF_FFFF, `PRID_INIT, "prid");
      expect_read(CONFIG, 3'd1, 32'hFFFF_FFFF, `CONFIG1_INIT, "config1");
   endtask

   task automatic check_exceptions();
      exc_code_e codes [6] = '{INT, SYS, BP, RI, OV, ADES};
      repeat (4) begin
         take_exception(codes[{$random(seed)} % 6], $random(seed), 1'($random(seed)),
                        $random(seed));
         take_exception(ERET, 32'h0, 1'b0, 32'h0);
      end
   endtask

   task automatic check_timer();
      logic [31:0] c;
      @(negedge clk);
      addr = COUNT;
      sel  = 3'd0;
      @(negedge clk);
      count_base = rdata;
      count_gap  = 10 + {$random(seed)} % 30;
      repeat (count_gap) @(negedge clk);
      chk_count = 1'b1;
      @(negedge clk);
      chk_count = 1'b0;
      c     = rdata;
      addr  = COMPARE;
      wen   = 1'b1;
      wdata = c + 32'd6;
      @(negedge clk);
      wen         = 1'b0;
      timer_wait  = 0;
      timer_armed = 1'b1;
      while (!cause[`IP7_BIT] && timer_wait < 15) begin
         @(negedge clk);
         timer_wait++;
      end
      timer_armed = 1'b0;
      mtc0(COMPARE, 3'd0, 32'h0);
      expect_read(CAUSE, 3'd0, 32'h1 << `IP7_BIT, 32'h0, "cause.ip7");
   endtask

   task automatic check_random_walk();
      int w;
      repeat (5) begin
         w = {$random(seed)} % `TLB_NUM;
         mtc0(WIRED, 3'd0, w);
         wired_ref = w;
         addr      = RANDOM;
         chk_rand  = 1'b1;
         repeat (2 * `TLB_NUM) @(negedge clk);
         chk_rand = 1'b0;
      end
   endtask

   task automatic check_tlb();
      logic [31:0] hi, lo0, lo1, msk;
      logic [11:0] km;
      logic        g;
      int          j;
      for (int i = 0; i < `TLB_NUM; i++) begin
         hi       = $random(seed) & `ENTRY_HI_WMASK;
         hi[31 -: `TLB_IDX_W] = i[`TLB_IDX_W-1:0];  // top VPN2 bits keep entries apart
         lo0      = $random(seed) & `ENTRY_LO_WMASK;
         lo1      = $random(seed) & `ENTRY_LO_WMASK;
         msk      = $random(seed) & `PAGE_MASK_WMASK;
         hi_ref[i]   = hi;
         lo0_ref[i]  = lo0;
         lo1_ref[i]  = lo1;
         mask_ref[i] = msk;
         mtc0(ENTRY_HI, 3'd0, hi);
         mtc0(ENTRY_LO0, 3'd0, lo0);
         mtc0(ENTRY_LO1, 3'd0, lo1);
         mtc0(PAGE_MASK, 3'd0, msk);
         mtc0(INDEX, 3'd0, i);
         tlb_cmd(TLBWI);
      end
      repeat (4) begin
         j = {$random(seed)} % `TLB_NUM;
         mtc0(ENTRY_HI, 3'd0, hi_ref[j]);
         tlb_cmd(TLBP);
         expect_read(INDEX, 3'd0, 32'h8000_0000 | `INDEX_WMASK, j, "index after tlbp hit");
         // VPN2 bit 12 is never covered by a page mask
         mtc0(ENTRY_HI, 3'd0, hi_ref[j] ^ 32'h0200_0000);
         tlb_cmd(TLBP);
         expect_read(INDEX, 3'd0, 32'h8000_0000, 32'h8000_0000, "index after tlbp miss");
      end
      repeat (4) begin
         j = {$random(seed)} % `TLB_NUM;
         mtc0(INDEX, 3'd0, j);
         tlb_cmd(TLBR);
         km  = mask_ref[j][`MASK_BITS];
         g   = lo0_ref[j][0] & lo1_ref[j][0];
         hi  = hi_ref[j];
         lo0 = lo0_ref[j];
         lo1 = lo1_ref[j];
         hi[`VPN2_BITS] = hi[`VPN2_BITS] & ~{7'b0, km};
         // mask bit 13+k covers PFN bit k+1
         lo0[`PFN_BITS] = lo0[`PFN_BITS] & ~{7'b0, km, 1'b0};
         lo1[`PFN_BITS] = lo1[`PFN_BITS] & ~{7'b0, km, 1'b0};
         lo0[0] = g;
         lo1[0] = g;
         expect_read(ENTRY_HI, 3'd0, 32'hFFFF_FFFF, hi, "entry_hi after tlbr");
         expect_read(ENTRY_LO0, 3'd0, 32'hFFFF_FFFF, lo0, "entry_lo0 after tlbr");
         expect_read(ENTRY_LO1, 3'd0, 32'hFFFF_FFFF, lo1, "entry_lo1 after tlbr");
         expect_read(PAGE_MASK, 3'd0, 32'hFFFF_FFFF, mask_ref[j], "page_mask after tlbr");
      end
   endtask

   task automatic check_addr_capture();
      logic [31:0] bad, ctx, ctx_msk;
      repeat (3) begin
         bad     = $random(seed);
         ctx     = 32'h0;
         ctx_msk = 32'h0;
         ctx[`BAD_VPN2_BITS]     = bad[`VPN2_BITS];
         ctx_msk[`BAD_VPN2_BITS] = '1;
         take_exception(TLBL, $random(seed), 1'b0, bad);
         expect_read(ENTRY_HI, 3'd0, 32'hFFFF_E000, bad, "entry_hi.vpn2");
         expect_read(CONTEXT, 3'd0, ctx_msk, ctx, "context.badvpn2");
         bad = $random(seed);
         take_exception(ADEL, $random(seed), 1'b0, bad);
         expect_read(BADVADDR, 3'd0, 32'hFFFF_FFFF, bad, "badvaddr");
      end
   endtask

   initial begin
      #(400 * GROUPS * PERIOD);
      $display("Watchdog expired after %0d cycles, run stopped", 400 * GROUPS);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst             = 1'b1;
      ext_int         = 6'b0;
      stall           = 1'b0;
      addr            = INDEX;
      sel             = 3'd0;
      wen             = 1'b0;
      wdata           = 32'h0;
      flush_exception = 1'b0;
      except_type     = INT;
      pc              = 32'h0;
      in_delayslot    = 1'b0;
      badvaddr        = 32'h0;
      tlb_op          = NONE;
      chk_rd          = 1'b0;
      chk_rand        = 1'b0;
      chk_exc         = 1'b0;
      chk_eret        = 1'b0;
      chk_count       = 1'b0;
      timer_armed     = 1'b0;
      wired_ref       = 32'h0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      check_registers();
      check_exceptions();
      check_timer();
      check_random_walk();
      check_tlb();
      check_addr_capture();
      repeat (2) @(negedge clk);
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/cp0_pkg.sv
rtl/tlb_entry.sv
rtl/tlb_write_ctrl.sv
rtl/tlb_probe_read.sv
rtl/cp0_regs.sv
rtl/mmu_cp0_top.sv
dv/mmu_cp0_tb.sv

// ==== Makefile ====
TOP = mmu_cp0_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
